// ==== include/pci_bridge_params.svh ====
/* pci bridge constants */

`ifndef PCI_BRIDGE_PARAMS_SVH
`define PCI_BRIDGE_PARAMS_SVH

// identification words of the configuration header
`define PCI_VENDOR_ID          16'h10ee
`define PCI_DEVICE_ID          16'h9500
// other bridge
`define PCI_CLASS_CODE         24'h068000
`define PCI_REVISION           8'h01
`define PCI_SUBSYS_ID          16'h0001
`define PCI_SUBSYS_VENDOR_ID   16'hbebe

// dword indices into configuration space
`define CFG_IDX_ID             6'd0
`define CFG_IDX_CMD            6'd1
`define CFG_IDX_CLASS          6'd2
`define CFG_IDX_BAR0           6'd4
`define CFG_IDX_SUBSYS         6'd11
`define CFG_IDX_INTR           6'd15
// relocation register at 50h, failed address at 5ch
`define CFG_IDX_WB_BASE        6'd20
`define CFG_IDX_FAILED         6'd23

// strobe cycles without ack before the access is dropped
`define WB_TIMEOUT_CYCLES      16
`define WB_TIMEOUT_DATA        32'hffff_ffff

`endif

// ==== design/pci_bridge_pkg.sv ====
/* pci bridge types */

package pci_bridge_pkg;

   // pci bus commands as seen on c/be# in the address phase
   typedef enum logic [3:0] {
      cmd_mem_read  = 4'b0110,
      cmd_mem_write = 4'b0111,
      cmd_cfg_read  = 4'b1010,
      cmd_cfg_write = 4'b1011
   } pci_cmd_e;

   // pci target FSM
   typedef enum logic [2:0] {
      st_idle,
      st_busy,
      st_cfg_read,
      st_cfg_write,
      st_mem_read,
      st_mem_write,
      st_turnaround
   } target_state_e;

   // wishbone master FSM
   typedef enum logic [1:0] {
      wb_idle,
      wb_request,
      wb_access,
      wb_finish
   } wb_state_e;

endpackage

// ==== design/pci_target.sv ====
/* pci target interface */

module pci_target (
   input  logic        clk,
   input  logic        wb_reset_i,
   input  logic        frame_n_i,
   input  logic        irdy_n_i,
   input  logic [3:0]  cbe_n_i,
   input  logic [31:0] ad_i,
   input  logic        addr_hit_i,
   input  logic        cfg_hit_i,
   input  logic [31:0] cfg_rdata_i,
   input  logic [9:0]  wb_base_i,
   input  logic        req_ready_i,
   input  logic        rsp_valid_i,
   input  logic [31:0] rsp_data_i,
   output logic [31:0] ad_o,
   output logic        ad_oe_o,
   output logic        trdy_n_o,
   output logic        devsel_n_o,
   output logic        ctrl_oe_o,
   output logic        par_o,
   output logic        par_oe_o,
   output logic        cfg_we_o,
   output logic [5:0]  cfg_idx_o,
   output logic [31:0] cfg_wdata_o,
   output logic        req_valid_o,
   output logic        req_write_o,
   output logic [29:0] req_addr_o,
   output logic [31:0] req_data_o,
   output logic [3:0]  req_sel_o
);

   pci_bridge_pkg::target_state_e state;
   logic [5:0] idx_q;
   logic       data_done;
   logic       read_state;

   // data phase completes when both ready strobes are low
   assign data_done  = !trdy_n_o && !irdy_n_i;
   assign read_state = (state == pci_bridge_pkg::st_cfg_read) ||
                       (state == pci_bridge_pkg::st_mem_read);

   // config writes go straight through on the completing edge
   assign cfg_idx_o   = idx_q;
   assign cfg_wdata_o = ad_i;
   assign cfg_we_o    = (state == pci_bridge_pkg::st_cfg_write) && data_done;

   always_ff @(posedge clk) begin
      if (wb_reset_i) begin
         state       <= pci_bridge_pkg::st_idle;
         devsel_n_o  <= 1'b1;
         trdy_n_o    <= 1'b1;
         ctrl_oe_o   <= 1'b0;
         ad_oe_o     <= 1'b0;
         par_oe_o    <= 1'b0;
         req_valid_o <= 1'b0;
      end else begin
         // parity drive lasts a single cycle
         par_oe_o <= 1'b0;
         case (state)
            pci_bridge_pkg::st_idle: begin
               if (!frame_n_i) begin
                  idx_q <= ad_i[7:2];
                  // dword address, upper relocation bits fall outside 30 bits
                  req_addr_o <= {wb_base_i[7:0], ad_i[23:2]};
                  if (cfg_hit_i || addr_hit_i) begin
                     devsel_n_o <= 1'b0;
                     ctrl_oe_o  <= 1'b1;
                     case (pci_bridge_pkg::pci_cmd_e'(cbe_n_i))
                        pci_bridge_pkg::cmd_cfg_read:  state <= pci_bridge_pkg::st_cfg_read;
                        pci_bridge_pkg::cmd_cfg_write: state <= pci_bridge_pkg::st_cfg_write;
                        pci_bridge_pkg::cmd_mem_read: begin
                           // reads ask the master at once, whole dword
                           state       <= pci_bridge_pkg::st_mem_read;
                           req_valid_o <= 1'b1;
                           req_write_o <= 1'b0;
                           req_sel_o   <= 4'hf;
                        end
                        pci_bridge_pkg::cmd_mem_write: begin
                           state       <= pci_bridge_pkg::st_mem_write;
                           req_write_o <= 1'b1;
                        end
                        default: state <= pci_bridge_pkg::st_busy;
                     endcase
                  end else begin
                     state <= pci_bridge_pkg::st_busy;
                  end
               end
            end
            pci_bridge_pkg::st_busy: begin
               // someone else's cycle, wait for frame to rise
               if (frame_n_i) begin
                  state <= pci_bridge_pkg::st_idle;
               end
            end
            pci_bridge_pkg::st_cfg_read: begin
               if (trdy_n_o) begin
                  ad_o     <= cfg_rdata_i;
                  ad_oe_o  <= 1'b1;
                  trdy_n_o <= 1'b0;
               end
            end
            pci_bridge_pkg::st_cfg_write: begin
               trdy_n_o <= 1'b0;
            end
            pci_bridge_pkg::st_mem_read: begin
               if (req_valid_o && req_ready_i) begin
                  req_valid_o <= 1'b0;
               end
               // wait states until the wishbone read returns
               if (rsp_valid_i && !req_valid_o && trdy_n_o) begin
                  ad_o     <= rsp_data_i;
                  ad_oe_o  <= 1'b1;
                  trdy_n_o <= 1'b0;
               end
            end
            pci_bridge_pkg::st_mem_write: begin
               if (req_valid_o && req_ready_i) begin
                  // master has the data, release the initiator
                  req_valid_o <= 1'b0;
                  trdy_n_o    <= 1'b0;
               end else if (!req_valid_o && trdy_n_o && !irdy_n_i) begin
                  req_data_o  <= ad_i;
                  req_sel_o   <= ~cbe_n_i;
                  req_valid_o <= 1'b1;
               end
            end
            pci_bridge_pkg::st_turnaround: begin
               ctrl_oe_o <= 1'b0;
               state     <= pci_bridge_pkg::st_idle;
            end
            default: state <= pci_bridge_pkg::st_idle;
         endcase
         // end of the data phase, drive strobes high for turnaround
         if (data_done) begin
            state      <= pci_bridge_pkg::st_turnaround;
            trdy_n_o   <= 1'b1;
            devsel_n_o <= 1'b1;
            ad_oe_o    <= 1'b0;
            if (read_state) begin
               // even parity over ad and c/be#, one clock late
               par_o    <= ^{ad_o, cbe_n_i};
               par_oe_o <= 1'b1;
            end
         end
      end
   end

endmodule

// ==== design/pci_config_space.sv ====
/* pci configuration registers */

`include "pci_bridge_params.svh"

module pci_config_space (
   input  logic        clk,
   input  logic        wb_reset_i,
   input  logic        idsel_i,
   input  logic [3:0]  cbe_n_i,
   input  logic [31:0] ad_i,
   input  logic        cfg_we_i,
   input  logic [5:0]  cfg_idx_i,
   input  logic [31:0] cfg_wdata_i,
   input  logic        fail_valid_i,
   input  logic [29:0] fail_addr_i,
   input  logic        wb_irq_i,
   output logic [31:0] cfg_rdata_o,
   output logic        addr_hit_o,
   output logic        cfg_hit_o,
   output logic [9:0]  wb_base_o,
   output logic        inta_n_o
);

   logic [7:0]  bar_q;
   logic        mem_en_q;
   logic        int_dis_q;
   logic [7:0]  int_line_q;
   logic [29:0] failed_addr_q;

   // type 0 config access, dword aligned
   assign cfg_hit_o = idsel_i && (ad_i[1:0] == 2'b00) &&
                      ((cbe_n_i == pci_bridge_pkg::cmd_cfg_read) ||
                       (cbe_n_i == pci_bridge_pkg::cmd_cfg_write));
   // 16 MB window selected by the top address byte
   assign addr_hit_o = mem_en_q && (ad_i[31:24] == bar_q) &&
                       ((cbe_n_i == pci_bridge_pkg::cmd_mem_read) ||
                        (cbe_n_i == pci_bridge_pkg::cmd_mem_write));

   assign inta_n_o = !(wb_irq_i && !int_dis_q);

   always_ff @(posedge clk) begin
      if (wb_reset_i) begin
         bar_q         <= '0;
         mem_en_q      <= 1'b0;
         int_dis_q     <= 1'b0;
         int_line_q    <= '0;
         wb_base_o     <= '0;
         failed_addr_q <= '0;
      end else begin
         if (cfg_we_i) begin
            case (cfg_idx_i)
               `CFG_IDX_CMD: begin
                  mem_en_q  <= cfg_wdata_i[1];
                  int_dis_q <= cfg_wdata_i[10];
               end
               `CFG_IDX_BAR0:    bar_q      <= cfg_wdata_i[31:24];
               `CFG_IDX_INTR:    int_line_q <= cfg_wdata_i[7:0];
               `CFG_IDX_WB_BASE: wb_base_o  <= cfg_wdata_i[31:22];
               default: ;
            endcase
         end
         // wishbone timeout capture
         if (fail_valid_i) begin
            failed_addr_q <= fail_addr_i;
         end
      end
   end

   always_comb begin
      case (cfg_idx_i)
         `CFG_IDX_ID:      cfg_rdata_o = {`PCI_DEVICE_ID, `PCI_VENDOR_ID};
         // status bit 19 mirrors the wishbone interrupt
         `CFG_IDX_CMD:     cfg_rdata_o = {12'b0, wb_irq_i, 8'b0, int_dis_q, 8'b0, mem_en_q, 1'b0};
         `CFG_IDX_CLASS:   cfg_rdata_o = {`PCI_CLASS_CODE, `PCI_REVISION};
         `CFG_IDX_BAR0:    cfg_rdata_o = {bar_q, 24'b0};
         `CFG_IDX_SUBSYS:  cfg_rdata_o = {`PCI_SUBSYS_ID, `PCI_SUBSYS_VENDOR_ID};
         // pin reads as inta
         `CFG_IDX_INTR:    cfg_rdata_o = {16'b0, 8'h01, int_line_q};
         `CFG_IDX_WB_BASE: cfg_rdata_o = {wb_base_o, 22'b0};
         `CFG_IDX_FAILED:  cfg_rdata_o = {failed_addr_q, 2'b00};
         default:          cfg_rdata_o = '0;
      endcase
   end

endmodule

// ==== design/wb_master.sv ====
/* wishbone single cycle master */

`include "pci_bridge_params.svh"

module wb_master (
   input  logic        clk,
   input  logic        wb_reset_i,
   input  logic        req_valid_i,
   input  logic        req_write_i,
   input  logic [29:0] req_addr_i,
   input  logic [31:0] req_data_i,
   input  logic [3:0]  req_sel_i,
   input  logic [31:0] wb_dat_i,
   input  logic        wb_ack_i,
   input  logic        wb_gnt_i,
   output logic        req_ready_o,
   output logic        rsp_valid_o,
   output logic [31:0] rsp_data_o,
   output logic        fail_valid_o,
   output logic [29:0] fail_addr_o,
   output logic [31:0] wb_adr_o,
   output logic [31:0] wb_dat_o,
   output logic [3:0]  wb_sel_o,
   output logic        wb_cyc_o,
   output logic        wb_stb_o,
   output logic        wb_we_o,
   output logic        wb_req_o
);

   localparam int TO_W = $clog2(`WB_TIMEOUT_CYCLES);

   pci_bridge_pkg::wb_state_e state;
   logic [29:0]     adr_q;
   logic            we_q;
   logic [TO_W-1:0] to_cnt;

   // accept a new request only with nothing in flight
   assign req_ready_o = (state == pci_bridge_pkg::wb_idle);
   // dword address, zero extended
   assign wb_adr_o    = {2'b00, adr_q};
   assign fail_addr_o = adr_q;

   always_ff @(posedge clk) begin
      if (wb_reset_i) begin
         state        <= pci_bridge_pkg::wb_idle;
         wb_req_o     <= 1'b0;
         wb_cyc_o     <= 1'b0;
         wb_stb_o     <= 1'b0;
         wb_we_o      <= 1'b0;
         rsp_valid_o  <= 1'b0;
         fail_valid_o <= 1'b0;
         to_cnt       <= '0;
      end else begin
         case (state)
            pci_bridge_pkg::wb_idle: begin
               if (req_valid_i) begin
                  adr_q    <= req_addr_i;
                  we_q     <= req_write_i;
                  wb_dat_o <= req_data_i;
                  wb_sel_o <= req_sel_i;
                  wb_req_o <= 1'b1;
                  state    <= pci_bridge_pkg::wb_request;
               end
            end
            pci_bridge_pkg::wb_request: begin
               // hold the request until the arbiter grants
               if (wb_gnt_i) begin
                  wb_cyc_o <= 1'b1;
                  wb_stb_o <= 1'b1;
                  wb_we_o  <= we_q;
                  to_cnt   <= '0;
                  state    <= pci_bridge_pkg::wb_access;
               end
            end
            pci_bridge_pkg::wb_access: begin
               to_cnt <= to_cnt + 1'b1;
               if (wb_ack_i || (to_cnt == TO_W'(`WB_TIMEOUT_CYCLES - 1))) begin
                  wb_cyc_o    <= 1'b0;
                  wb_stb_o    <= 1'b0;
                  wb_we_o     <= 1'b0;
                  wb_req_o    <= 1'b0;
                  rsp_valid_o <= 1'b1;
                  state       <= pci_bridge_pkg::wb_finish;
                  if (wb_ack_i) begin
                     rsp_data_o <= wb_dat_i;
                  end else begin
                     // no ack in time, return all ones and log the address
                     rsp_data_o   <= `WB_TIMEOUT_DATA;
                     fail_valid_o <= 1'b1;
                  end
               end
            end
            pci_bridge_pkg::wb_finish: begin
               rsp_valid_o  <= 1'b0;
               fail_valid_o <= 1'b0;
               state        <= pci_bridge_pkg::wb_idle;
            end
            default: state <= pci_bridge_pkg::wb_idle;
         endcase
      end
   end

endmodule

// ==== design/pci_bridge_top.sv ====
/* pci to wishbone bridge */

module pci_bridge_top (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic        frame_n_i,
   input  logic        irdy_n_i,
   input  logic        idsel_i,
   input  logic [3:0]  cbe_n_i,
   input  logic [31:0] ad_i,
   input  logic [31:0] wb_dat_i,
   input  logic        wb_ack_i,
   input  logic        wb_irq_i,
   input  logic        wb_gnt_i,
   output logic [31:0] ad_o,
   output logic        ad_oe_o,
   output logic        trdy_n_o,
   output logic        devsel_n_o,
   output logic        ctrl_oe_o,
   output logic        par_o,
   output logic        par_oe_o,
   output logic        inta_n_o,
   output logic [31:0] wb_adr_o,
   output logic [31:0] wb_dat_o,
   output logic [3:0]  wb_sel_o,
   output logic        wb_cyc_o,
   output logic        wb_stb_o,
   output logic        wb_we_o,
   output logic        wb_req_o,
   output logic        wb_reset_o
);

   // target to config space
   logic        addr_hit, cfg_hit, cfg_we;
   logic [5:0]  cfg_idx;
   logic [31:0] cfg_rdata, cfg_wdata;
   logic [9:0]  wb_base;
   // target to master request and response
   logic        req_valid, req_ready, req_write;
   logic [29:0] req_addr;
   logic [31:0] req_data;
   logic [3:0]  req_sel;
   logic        rsp_valid;
   logic [31:0] rsp_data;
   // timeout report
   logic        fail_valid;
   logic [29:0] fail_addr;

   // pci reset is active low, registered into the active high reset
   always_ff @(posedge clk) begin
      wb_reset_o <= ~rst_n_i;
   end

   pci_target u_target (
      .clk(clk), .wb_reset_i(wb_reset_o), .frame_n_i(frame_n_i), .irdy_n_i(irdy_n_i),
      .cbe_n_i(cbe_n_i), .ad_i(ad_i), .addr_hit_i(addr_hit), .cfg_hit_i(cfg_hit),
      .cfg_rdata_i(cfg_rdata), .wb_base_i(wb_base), .req_ready_i(req_ready),
      .rsp_valid_i(rsp_valid), .rsp_data_i(rsp_data), .ad_o(ad_o), .ad_oe_o(ad_oe_o),
      .trdy_n_o(trdy_n_o), .devsel_n_o(devsel_n_o), .ctrl_oe_o(ctrl_oe_o),
      .par_o(par_o), .par_oe_o(par_oe_o), .cfg_we_o(cfg_we), .cfg_idx_o(cfg_idx),
      .cfg_wdata_o(cfg_wdata), .req_valid_o(req_valid), .req_write_o(req_write),
      .req_addr_o(req_addr), .req_data_o(req_data), .req_sel_o(req_sel)
   );

   pci_config_space u_cfg (
      .clk(clk), .wb_reset_i(wb_reset_o), .idsel_i(idsel_i), .cbe_n_i(cbe_n_i),
      .ad_i(ad_i), .cfg_we_i(cfg_we), .cfg_idx_i(cfg_idx), .cfg_wdata_i(cfg_wdata),
      .fail_valid_i(fail_valid), .fail_addr_i(fail_addr), .wb_irq_i(wb_irq_i),
      .cfg_rdata_o(cfg_rdata), .addr_hit_o(addr_hit), .cfg_hit_o(cfg_hit),
      .wb_base_o(wb_base), .inta_n_o(inta_n_o)
   );

   wb_master u_master (
      .clk(clk), .wb_reset_i(wb_reset_o), .req_valid_i(req_valid),
      .req_write_i(req_write), .req_addr_i(req_addr), .req_data_i(req_data),
      .req_sel_i(req_sel), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i), .wb_gnt_i(wb_gnt_i),
      .req_ready_o(req_ready), .rsp_valid_o(rsp_valid), .rsp_data_o(rsp_data),
      .fail_valid_o(fail_valid), .fail_addr_o(fail_addr), .wb_adr_o(wb_adr_o),
      .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o), .wb_cyc_o(wb_cyc_o),
      .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o), .wb_req_o(wb_req_o)
   );

endmodule

// ==== test/tb_clock_gen.sv ====
/* testbench clock */

module tb_clock_gen (
   output logic clk_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // 20 ns period
   initial clk_o = 1'b0;
   always #10 clk_o = ~clk_o;
endmodule

// ==== test/pci_bridge_properties.sv ====
/* bridge bus rules */

module pci_bridge_properties (
   input logic        clk,
   input logic        wb_reset_o,
   input logic        req_valid,
   input logic        req_ready,
   input logic        req_write,
   input logic [29:0] req_addr,
   input logic [31:0] req_data,
   input logic [3:0]  req_sel,
   input logic        wb_gnt_i,
   input logic        wb_cyc_o,
   input logic        wb_stb_o,
   input logic        trdy_n_o,
   input logic        devsel_n_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // request held with stable fields until the master takes it
   req_hold: assert property (@(posedge clk) disable iff (wb_reset_o)
      req_valid && !req_ready |=> req_valid && $stable(req_write) &&
      $stable(req_addr) && $stable(req_data) && $stable(req_sel))
      else $error("request dropped or changed before ready");

   // strobe only inside a cycle, a new strobe only after grant
   stb_in_cyc: assert property (@(posedge clk) disable iff (wb_reset_o)
      wb_stb_o |-> wb_cyc_o && ($past(wb_stb_o) || $past(wb_gnt_i)))
      else $error("wb_stb_o without wb_cyc_o or without grant");

   // target ready only while selected
   trdy_devsel: assert property (@(posedge clk) disable iff (wb_reset_o)
      !trdy_n_o |-> !devsel_n_o)
      else $error("trdy_n_o low while devsel_n_o high");
endmodule

bind pci_bridge_top pci_bridge_properties props (.*);

// ==== test/pci_bridge_tb.sv ====
/* pci bridge testbench */

`include "pci_bridge_params.svh"

module pci_bridge_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int K_CRD = 0, K_CWR = 1, K_MRD = 2, K_MWR = 3, K_MISS = 4, K_MWRH = 5;

   typedef struct {
      int          kind;
      logic [31:0] addr;
      logic [31:0] data;
      logic [3:0]  cbe;
      bit          ack_mode;
      logic [31:0] exp;
      bit          irq;
      bit          exp_inta;
   } row_t;

   logic        clk, rst_n_i, frame_n_i, irdy_n_i, idsel_i, wb_ack_i, wb_irq_i, wb_gnt_i;
   logic [3:0]  cbe_n_i;
   logic [31:0] ad_i, wb_dat_i;
   logic [31:0] ad_o, wb_adr_o, wb_dat_o;
   logic        ad_oe_o, trdy_n_o, devsel_n_o, ctrl_oe_o, par_o, par_oe_o, inta_n_o;
   logic [3:0]  wb_sel_o;
   logic        wb_cyc_o, wb_stb_o, wb_we_o, wb_req_o, wb_reset_o;

   row_t        rows[$];
   logic [31:0] mem[16];
   logic [31:0] seed, rec_adr, rec_dat, rd;
   logic [3:0]  rec_sel;
   logic [9:0]  base;
   int          wait_cnt, wr_count, exp_writes;
   bit          ack_mode;
   bit          is_read;

   tb_clock_gen clk_gen (.clk_o(clk));
   pci_bridge_top dut (.*);

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // memory contents as a function of the full word index
   function automatic logic [31:0] fill(input int i);
      return 32'hc3a5_0000 ^ (i * 32'h9e37_79b1);
   endfunction

   task automatic check_value(input bit ok, input string msg);
      assert (ok) else begin
         $display("ERROR at %0t ns: %s", $time, msg);
         $display("TEST RESULT: FAIL");
         $fatal(1);
      end
   endtask

   task automatic add_row(input int k, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] c, input bit am, input logic [31:0] e,
                          input bit irq, input bit inta);
      row_t r;
      r = '{k, a, d, c, am, e, irq, inta};
      rows.push_back(r);
   endtask

   // wishbone slave, random ack delay
   always @(negedge clk) begin
      if (wb_ack_i) begin
         wb_ack_i <= 1'b0;
      end else if (wb_cyc_o && wb_stb_o && ack_mode) begin
         if (wait_cnt == 0) begin
            wb_ack_i <= 1'b1;
            wb_dat_i <= mem[wb_adr_o[3:0]];
            if (wb_we_o) begin
               mem[wb_adr_o[3:0]] <= wb_dat_o;
               rec_adr  <= wb_adr_o;
               rec_dat  <= wb_dat_o;
               rec_sel  <= wb_sel_o;
               wr_count <= wr_count + 1;
            end
            seed     = lcg_next(seed);
            wait_cnt <= int'(seed[23:16]) % 6;
         end else begin
            wait_cnt <= wait_cnt - 1;
         end
      end
   end

   task automatic run_row(input row_t r);
      @(negedge clk);
      wb_irq_i  = r.irq;
      ack_mode  = r.ack_mode;
      // grant held off so the next request sees a busy master
      wb_gnt_i  = (r.kind != K_MWRH);
      frame_n_i = 1'b0;
      ad_i      = r.addr;
      idsel_i   = (r.kind == K_CRD) || (r.kind == K_CWR);
      is_read   = (r.kind == K_CRD) || (r.kind == K_MRD);
      case (r.kind)
         K_CRD:         cbe_n_i = 4'b1010;
         K_CWR:         cbe_n_i = 4'b1011;
         K_MWR, K_MWRH: cbe_n_i = 4'b0111;
         default:       cbe_n_i = 4'b0110;
      endcase
      @(negedge clk);
      frame_n_i = 1'b1;
      idsel_i   = 1'b0;
      irdy_n_i  = 1'b0;
      ad_i      = r.data;
      cbe_n_i   = r.cbe;
      if (r.kind == K_MWR || r.kind == K_MWRH) begin
         exp_writes = exp_writes + 1;
      end
      if (r.kind == K_MISS) begin
         repeat (6) begin
            check_value(devsel_n_o && !ctrl_oe_o, "devsel_n_o or ctrl_oe_o asserted on a miss");
            @(negedge clk);
         end
      end else begin
         while (trdy_n_o) @(negedge clk);
         check_value(!devsel_n_o && ctrl_oe_o, "trdy_n_o low without devsel_n_o or ctrl_oe_o");
         check_value(ad_oe_o == is_read, "ad_oe_o wrong in the data phase");
         rd = ad_o;
         @(negedge clk);
         check_value(trdy_n_o && devsel_n_o && ctrl_oe_o && !ad_oe_o,
                     "strobes or enables wrong in the turnaround cycle");
         if (is_read) begin
            check_value(rd == r.exp, $sformatf("read %h, expected %h", rd, r.exp));
            check_value(par_oe_o && par_o == ^{r.exp, r.cbe}, "read parity wrong");
         end else begin
            check_value(!par_oe_o, "par_oe_o high after a write");
         end
      end
      irdy_n_i = 1'b1;
      cbe_n_i  = 4'hf;
      @(negedge clk);
      check_value(!ctrl_oe_o && !ad_oe_o && !par_oe_o, "pci drivers enabled after the cycle");
      if (r.kind == K_MWR) begin
         while (wb_req_o) @(negedge clk);
         check_value(wr_count == exp_writes, "wrong number of wishbone writes");
         check_value(rec_adr == {base, r.addr[23:2]}, $sformatf("wb address %h", rec_adr));
         check_value(rec_dat == r.data && rec_sel == ~r.cbe, "wb write data or sel wrong");
      end else if (r.kind == K_MWRH) begin
         check_value(wb_req_o && !wb_cyc_o, "wishbone cycle started without grant");
      end
      check_value(inta_n_o == r.exp_inta, "inta_n_o wrong");
   endtask

   // watchdog sized from the table length
   initial begin
      #1;
      #((rows.size() * 60 + 10) * 20);
      $display("timeout: the test did not finish in time");
      $display("TEST RESULT: FAIL");
      $fatal(1);
   end

   initial begin
      rst_n_i = 1'b0;
      frame_n_i = 1'b1;
      irdy_n_i = 1'b1;
      idsel_i = 1'b0;
      cbe_n_i = 4'hf;
      ad_i = '0;
      wb_dat_i = '0;
      wb_ack_i = 1'b0;
      wb_irq_i = 1'b0;
      wb_gnt_i = 1'b1;
      ack_mode = 1'b1;
      is_read = 1'b0;
      wr_count = 0;
      exp_writes = 0;
      seed = 32'hf22d90cb;
      wait_cnt = 0;
      base = 10'h032;
      for (int i = 0; i < 16; i++) mem[i] = fill(i);
      add_row(K_CRD, 32'h0, 0, 4'h0, 1, {`PCI_DEVICE_ID, `PCI_VENDOR_ID}, 0, 1);
      add_row(K_CRD, 32'h8, 0, 4'h0, 1, {`PCI_CLASS_CODE, `PCI_REVISION}, 0, 1);
      add_row(K_CRD, 32'h2c, 0, 4'h0, 1, {`PCI_SUBSYS_ID, `PCI_SUBSYS_VENDOR_ID}, 0, 1);
      add_row(K_MISS, 32'h1200_0010, 0, 4'h0, 1, 0, 0, 1);
      add_row(K_CWR, 32'h10, 32'h1234_5678, 4'h0, 1, 0, 0, 1);
      add_row(K_CRD, 32'h10, 0, 4'h0, 1, 32'h1200_0000, 0, 1);
      add_row(K_CWR, 32'h4, 32'h0000_0002, 4'h0, 1, 0, 0, 1);
      add_row(K_CRD, 32'h4, 0, 4'h0, 1, 32'h0000_0002, 0, 1);
      add_row(K_CWR, 32'h50, {base, 22'h3f_ffff}, 4'h0, 1, 0, 0, 1);
      add_row(K_CRD, 32'h50, 0, 4'h0, 1, {base, 22'h0}, 0, 1);
      add_row(K_MWRH, 32'h1200_0024, 32'h0bad_f00d, 4'h0, 1, 0, 0, 1);
      add_row(K_MWR, 32'h1200_0020, 32'hdead_beef, 4'b0101, 1, 0, 0, 1);
      add_row(K_MRD, 32'h1200_0024, 0, 4'h0, 1, 32'h0bad_f00d, 0, 1);
      add_row(K_MRD, 32'h1200_0010, 0, 4'h0, 1, fill(4), 0, 1);
      add_row(K_MRD, 32'h1200_0030, 0, 4'h0, 0, `WB_TIMEOUT_DATA, 0, 1);
      add_row(K_CRD, 32'h5c, 0, 4'h0, 1, {base, 22'hc} << 2, 0, 1);
      add_row(K_CRD, 32'h4, 0, 4'h0, 1, 32'h0008_0002, 1, 0);
      add_row(K_CWR, 32'h4, 32'h0000_0402, 4'h0, 1, 0, 1, 1);
      add_row(K_CRD, 32'h4, 0, 4'h0, 1, 32'h0008_0402, 1, 1);
      add_row(K_CRD, 32'h4, 0, 4'h0, 1, 32'h0000_0402, 0, 1);
      repeat (5) @(negedge clk);
      check_value(wb_reset_o && trdy_n_o && devsel_n_o && inta_n_o && !ctrl_oe_o &&
                  !ad_oe_o && !par_oe_o && !wb_cyc_o && !wb_stb_o && !wb_we_o &&
                  !wb_req_o, "outputs not inactive during reset");
      rst_n_i = 1'b1;
      repeat (2) @(negedge clk);
      check_value(!wb_reset_o, "wb_reset_o still high after reset release");
      foreach (rows[i]) run_row(rows[i]);
      $display("TEST RESULT: PASS");
      $finish;
   end
endmodule

// ==== pci_bridge.f ====
+incdir+include
design/pci_bridge_pkg.sv
design/pci_target.sv
design/pci_config_space.sv
design/wb_master.sv
design/pci_bridge_top.sv
test/tb_clock_gen.sv
test/pci_bridge_properties.sv
test/pci_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the pci bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wall -Wno-fatal \
   -f pci_bridge.f --top-module pci_bridge_tb -o sim_pci_bridge
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/sim_pci_bridge
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

echo "simulation finished"
exit 0
